//--- include/lq_consts.svh
`ifndef LQ_CONSTS_SVH
`define LQ_CONSTS_SVH

// Queue numbering
`define LQ_NUM_QUEUES   8
`define LQ_QUEUE_BITS   3

// Shared pool of entry numbers
`define LQ_NUM_ENTRIES  64
`define LQ_ENTRY_BITS   6

// Holds 0 up to the full pool size
`define LQ_COUNT_BITS   7

// Read latency of the next-entry memory in cycles
`define LQ_LINK_DELAY   2

`endif

//--- verilog/lq_pkg.sv
`include "lq_consts.svh"

package lq_pkg;

  typedef logic [`LQ_QUEUE_BITS-1:0] queue_id_t;
  typedef logic [`LQ_ENTRY_BITS-1:0] entry_id_t;
  typedef logic [`LQ_COUNT_BITS-1:0] count_t;

  typedef enum logic {
    LQ_PUSH = 1'b0,
    LQ_POP  = 1'b1
  } lq_op_e;

  // The entry field of a client command only matters for a push
  typedef struct packed {
    lq_op_e    op;
    queue_id_t queue;
    entry_id_t entry;
  } lq_cmd_t;

  // Pop result
  typedef struct packed {
    entry_id_t entry;
    logic      empty;
  } lq_resp_t;

  // Head and occupancy of the selected queue
  typedef struct packed {
    entry_id_t head;
    count_t    count;
  } queue_state_t;

  // One write into the next-entry memory
  typedef struct packed {
    logic      en;
    entry_id_t addr;
    entry_id_t data;
  } link_wr_t;

endpackage

//--- verilog/lq_link_timer.sv
`timescale 1ns/1ps

`include "lq_consts.svh"

module lq_link_timer #(
  parameter int DELAY = `LQ_LINK_DELAY
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic done
);

  localparam int CNT_BITS = $clog2(DELAY + 1);

  logic [CNT_BITS-1:0] cnt;
  logic                running;

  // Loaded with DELAY-1 so that done lands DELAY cycles after start
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      cnt     <= '0;
    end else if (!running) begin
      if (start) begin
        running <= 1'b1;
        cnt     <= CNT_BITS'(DELAY - 1);
      end
    end else if (cnt == '0) begin
      running <= 1'b0;
    end else begin
      cnt <= cnt - CNT_BITS'(1);
    end
  end

  assign done = running && (cnt == '0);

endmodule

//--- verilog/lq_link_ram.sv
`timescale 1ns/1ps

`include "lq_consts.svh"

module lq_link_ram
  import lq_pkg::*;
(
  input  logic      clk,
  input  link_wr_t  link_wr,
  input  entry_id_t rd_addr,
  output entry_id_t rd_data
);

  // Next entry of each entry number
  entry_id_t mem [`LQ_NUM_ENTRIES];

  // Read address pipeline sets the fixed latency
  entry_id_t rd_pipe [`LQ_LINK_DELAY];

  always_ff @(posedge clk) begin
    if (link_wr.en) begin
      mem[link_wr.addr] <= link_wr.data;
    end
  end

  always_ff @(posedge clk) begin
    rd_pipe[0] <= rd_addr;
    for (int i = 1; i < `LQ_LINK_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = mem[rd_pipe[`LQ_LINK_DELAY-1]];

endmodule

//--- verilog/lq_queue_table.sv
`timescale 1ns/1ps

`include "lq_consts.svh"

module lq_queue_table
  import lq_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  queue_id_t    sel_queue,
  input  logic         push_en,
  input  entry_id_t    push_entry,
  input  logic         pop_en,
  input  logic         head_load,
  input  entry_id_t    new_head,
  output queue_state_t state,
  output link_wr_t     link_wr
);

  entry_id_t head  [`LQ_NUM_QUEUES];
  entry_id_t tail  [`LQ_NUM_QUEUES];
  count_t    count [`LQ_NUM_QUEUES];

  entry_id_t sel_tail;
  logic      sel_empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Selected queue view
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign sel_tail    = tail[sel_queue];
  assign sel_empty   = (count[sel_queue] == '0);
  assign state.head  = head[sel_queue];
  assign state.count = count[sel_queue];

  // A pushed entry is chained behind the current tail
  assign link_wr.en   = push_en && !sel_empty;
  assign link_wr.addr = sel_tail;
  assign link_wr.data = push_entry;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int q = 0; q < `LQ_NUM_QUEUES; q++) begin
        count[q] <= '0;
      end
    end else if (push_en) begin
      count[sel_queue] <= count[sel_queue] + count_t'(1);
    end else if (pop_en) begin
      count[sel_queue] <= count[sel_queue] - count_t'(1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Head and tail pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (push_en) begin
      tail[sel_queue] <= push_entry;
      // First entry of an empty queue is also its head
      if (sel_empty) begin
        head[sel_queue] <= push_entry;
      end
    end
    if (head_load) begin
      head[sel_queue] <= new_head;
    end
  end

endmodule

//--- verilog/lq_ctrl_fsm.sv
`timescale 1ns/1ps

module lq_ctrl_fsm
  import lq_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         req,
  input  lq_cmd_t      cmd,
  output logic         ack,
  output lq_resp_t     resp,
  output queue_id_t    sel_queue,
  output logic         push_en,
  output entry_id_t    push_entry,
  output logic         pop_en,
  output logic         head_load,
  output entry_id_t    new_head,
  input  queue_state_t state,
  output entry_id_t    link_rd_addr,
  input  entry_id_t    link_rd_data,
  output logic         timer_start,
  input  logic         timer_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,
    ST_WAIT_LINK,
    ST_ACK,
    ST_RELEASE
  } fsm_state_e;

  fsm_state_e st;
  lq_cmd_t    cmd_q;
  lq_resp_t   resp_q;
  logic       ack_q;
  logic       is_pop;
  logic       not_empty;
  logic       multi;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode of the latched command against the selected queue state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign is_pop    = (cmd_q.op == LQ_POP);
  assign not_empty = (state.count != '0);
  // More than one entry left means the successor has to come from the link memory
  assign multi     = (state.count > count_t'(1));

  assign sel_queue  = cmd_q.queue;
  assign push_entry = cmd_q.entry;
  assign push_en    = (st == ST_EXEC) && !is_pop;
  assign pop_en     = (st == ST_EXEC) && is_pop && not_empty;

  // The head is only replaced after the pop, so it stays the read address
  assign link_rd_addr = state.head;
  assign timer_start  = (st == ST_EXEC) && is_pop && multi;

  assign head_load = (st == ST_WAIT_LINK) && timer_done;
  assign new_head  = link_rd_data;

  assign ack  = ack_q;
  assign resp = resp_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencing and four-phase handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      st    <= ST_IDLE;
      ack_q <= 1'b0;
    end else begin
      case (st)
        ST_IDLE: begin
          if (req) begin
            st <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (is_pop && multi) begin
            st <= ST_WAIT_LINK;
          end else begin
            st <= ST_ACK;
          end
        end
        ST_WAIT_LINK: begin
          if (timer_done) begin
            st <= ST_ACK;
          end
        end
        ST_ACK: begin
          ack_q <= 1'b1;
          // Client holding req keeps us parked here
          if (ack_q && !req) begin
            st <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          ack_q <= 1'b0;
          st    <= ST_IDLE;
        end
        default: begin
          st    <= ST_IDLE;
          ack_q <= 1'b0;
        end
      endcase
    end
  end

  // Command and pop result
  always_ff @(posedge clk) begin
    if ((st == ST_IDLE) && req) begin
      cmd_q <= cmd;
    end
    if ((st == ST_EXEC) && is_pop) begin
      resp_q.entry <= state.head;
      resp_q.empty <= !not_empty;
    end
  end

endmodule

//--- verilog/lq_top.sv
`timescale 1ns/1ps

`include "lq_consts.svh"

module lq_top
  import lq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  lq_cmd_t  cmd,
  output logic     ack,
  output lq_resp_t resp
);

  queue_id_t    sel_queue;
  logic         push_en;
  entry_id_t    push_entry;
  logic         pop_en;
  logic         head_load;
  entry_id_t    new_head;
  queue_state_t q_state;
  entry_id_t    link_rd_addr;
  entry_id_t    link_rd_data;
  link_wr_t     link_wr;
  logic         timer_start;
  logic         timer_done;

  lq_ctrl_fsm i_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .cmd          (cmd),
    .ack          (ack),
    .resp         (resp),
    .sel_queue    (sel_queue),
    .push_en      (push_en),
    .push_entry   (push_entry),
    .pop_en       (pop_en),
    .head_load    (head_load),
    .new_head     (new_head),
    .state        (q_state),
    .link_rd_addr (link_rd_addr),
    .link_rd_data (link_rd_data),
    .timer_start  (timer_start),
    .timer_done   (timer_done)
  );

  // Runs alongside the link memory read so the FSM knows when data is valid
  lq_link_timer #(
    .DELAY (`LQ_LINK_DELAY)
  ) i_timer (
    .clk   (clk),
    .rst   (rst),
    .start (timer_start),
    .done  (timer_done)
  );

  lq_queue_table i_table (
    .clk        (clk),
    .rst        (rst),
    .sel_queue  (sel_queue),
    .push_en    (push_en),
    .push_entry (push_entry),
    .pop_en     (pop_en),
    .head_load  (head_load),
    .new_head   (new_head),
    .state      (q_state),
    .link_wr    (link_wr)
  );

  lq_link_ram i_link_ram (
    .clk     (clk),
    .link_wr (link_wr),
    .rd_addr (link_rd_addr),
    .rd_data (link_rd_data)
  );

endmodule

//--- testbench/lq_tb.sv
`timescale 1ns/1ps

`include "lq_consts.svh"

module lq_tb
  import lq_pkg::*;
();

  localparam int DRIVE_DELAY = 2;
  localparam int ACK_TIMEOUT = 20;
  localparam int MAX_ROWS    = 64;

  typedef struct packed {
    lq_op_e     op;
    queue_id_t  queue;
    entry_id_t  entry;
    entry_id_t  exp_entry;
    logic       exp_empty;
    logic [1:0] hold;
  } stim_row_t;

  logic        clk;
  logic        rst;
  logic        req;
  lq_cmd_t     cmd;
  logic        ack;
  lq_resp_t    resp;

  stim_row_t   tbl [MAX_ROWS];
  int          n_rows;
  logic [16:0] lfsr;

  // Reference queues kept as ring buffers
  entry_id_t   mdl_data [`LQ_NUM_QUEUES][`LQ_NUM_ENTRIES];
  int          mdl_rd   [`LQ_NUM_QUEUES];
  int          mdl_cnt  [`LQ_NUM_QUEUES];

  lq_top i_dut (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .cmd  (cmd),
    .ack  (ack),
    .resp (resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_now($sformatf("Mismatch on %s: got 0x%0h, expected 0x%0h",
                         name, actual, expected));
    end
  endtask

  // Taps at bits 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic idle_gap();
    logic [1:0] gap;
    gap = '0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = {gap[0], lfsr[0]};
    end
    repeat (gap) tick();
  endtask

  // Counts edges until ack reaches the given level
  task automatic wait_for_ack(input logic level, output int cycles);
    cycles = 0;
    do begin
      tick();
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        fail_now($sformatf("Timed out waiting for ack to become %0d", level));
      end
    end while (ack !== level);
  endtask

  task automatic add_row(input lq_op_e op, input int q, input int e, input int exp_e,
                         input logic exp_empty, input int hold);
    stim_row_t row;
    row.op        = op;
    row.queue     = queue_id_t'(q);
    row.entry     = entry_id_t'(e);
    row.exp_entry = entry_id_t'(exp_e);
    row.exp_empty = exp_empty;
    row.hold      = 2'(hold);
    tbl[n_rows]   = row;
    n_rows++;
  endtask

  task automatic model_pop(input queue_id_t q, output entry_id_t e, output logic empty);
    empty = (mdl_cnt[q] == 0);
    e     = '0;
    if (!empty) begin
      e          = mdl_data[q][mdl_rd[q]];
      mdl_rd[q]  = (mdl_rd[q] + 1) % `LQ_NUM_ENTRIES;
      mdl_cnt[q] = mdl_cnt[q] - 1;
    end
  endtask

  task automatic run_row(input int r);
    stim_row_t row;
    entry_id_t exp_entry;
    logic      exp_empty;
    int        exp_lat;
    int        cycles;
    row     = tbl[r];
    exp_lat = 2;
    if (row.op == LQ_POP) begin
      // Successor comes from the link memory only when more than one entry is queued
      if (mdl_cnt[row.queue] > 1) begin
        exp_lat = 2 + `LQ_LINK_DELAY;
      end
      model_pop(row.queue, exp_entry, exp_empty);
      if (exp_empty !== row.exp_empty || (!exp_empty && exp_entry !== row.exp_entry)) begin
        fail_now($sformatf("Table row %0d disagrees with the reference queue model", r));
      end
    end else begin
      mdl_data[row.queue][(mdl_rd[row.queue] + mdl_cnt[row.queue]) % `LQ_NUM_ENTRIES] =
        row.entry;
      mdl_cnt[row.queue] = mdl_cnt[row.queue] + 1;
    end
    cmd.op    = row.op;
    cmd.queue = row.queue;
    cmd.entry = row.entry;
    req       = 1'b1;
    wait_for_ack(1'b1, cycles);
    check_value("ack rise latency", cycles - 1, exp_lat);
    if (row.op == LQ_POP) begin
      check_value("resp.empty", resp.empty, exp_empty);
      if (!exp_empty) begin
        check_value("resp.entry", resp.entry, exp_entry);
      end
    end
    repeat (row.hold) begin
      tick();
      check_value("ack", ack, 1'b1);
    end
    req = 1'b0;
    wait_for_ack(1'b0, cycles);
    check_value("ack fall latency", cycles - 1, 1);
  endtask

  task automatic load_table();
    // Pops straight after reset
    add_row(LQ_POP,  0,  0,  0, 1'b1, 0);
    add_row(LQ_POP,  5,  0,  0, 1'b1, 1);
    // FIFO order within one queue
    add_row(LQ_PUSH, 2, 10,  0, 1'b0, 0);
    add_row(LQ_PUSH, 2, 11,  0, 1'b0, 2);
    add_row(LQ_PUSH, 2, 12,  0, 1'b0, 0);
    add_row(LQ_POP,  2,  0, 10, 1'b0, 3);
    add_row(LQ_POP,  2,  0, 11, 1'b0, 0);
    add_row(LQ_POP,  2,  0, 12, 1'b0, 1);
    add_row(LQ_POP,  2,  0,  0, 1'b1, 0);
    // Three queues interleaved
    add_row(LQ_PUSH, 1, 20,  0, 1'b0, 0);
    add_row(LQ_PUSH, 3, 30,  0, 1'b0, 0);
    add_row(LQ_PUSH, 6, 40,  0, 1'b0, 0);
    add_row(LQ_PUSH, 1, 21,  0, 1'b0, 0);
    add_row(LQ_PUSH, 3, 31,  0, 1'b0, 1);
    add_row(LQ_POP,  1,  0, 20, 1'b0, 0);
    add_row(LQ_PUSH, 6, 41,  0, 1'b0, 0);
    add_row(LQ_POP,  3,  0, 30, 1'b0, 2);
    add_row(LQ_PUSH, 1, 22,  0, 1'b0, 0);
    add_row(LQ_POP,  6,  0, 40, 1'b0, 0);
    add_row(LQ_POP,  1,  0, 21, 1'b0, 0);
    add_row(LQ_POP,  3,  0, 31, 1'b0, 0);
    add_row(LQ_POP,  1,  0, 22, 1'b0, 0);
    add_row(LQ_POP,  6,  0, 41, 1'b0, 0);
    add_row(LQ_POP,  6,  0,  0, 1'b1, 0);
    // Refill after a single-entry pop, with the extreme entry numbers
    add_row(LQ_PUSH, 4, 50,  0, 1'b0, 0);
    add_row(LQ_POP,  4,  0, 50, 1'b0, 0);
    add_row(LQ_PUSH, 4, 63,  0, 1'b0, 0);
    add_row(LQ_PUSH, 4,  0,  0, 1'b0, 0);
    add_row(LQ_POP,  4,  0, 63, 1'b0, 0);
    add_row(LQ_POP,  4,  0,  0, 1'b0, 0);
    add_row(LQ_POP,  4,  0,  0, 1'b1, 0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst    = 1'b1;
    req    = 1'b0;
    cmd    = '0;
    lfsr   = 17'd90825;
    n_rows = 0;
    for (int q = 0; q < `LQ_NUM_QUEUES; q++) begin
      mdl_rd[q]  = 0;
      mdl_cnt[q] = 0;
    end
    load_table();
    repeat (10) begin
      tick();
      check_value("ack", ack, 1'b0);
    end
    rst = 1'b0;
    tick();
    check_value("ack", ack, 1'b0);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
      idle_gap();
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- lq_manager.f
+incdir+include
verilog/lq_pkg.sv
verilog/lq_link_timer.sv
verilog/lq_link_ram.sv
verilog/lq_queue_table.sv
verilog/lq_ctrl_fsm.sv
verilog/lq_top.sv
testbench/lq_tb.sv

//--- Bender.yml
package:
  name: lq_manager

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/lq_pkg.sv
      - verilog/lq_link_timer.sv
      - verilog/lq_link_ram.sv
      - verilog/lq_queue_table.sv
      - verilog/lq_ctrl_fsm.sv
      - verilog/lq_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/lq_tb.sv
